//--- design/mult_macros.svh
/*
 * Width macros for the signed multiplier
 */
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// Operand width in bits
`define MULT_WIDTH 32

// Full product width
// Twice the operand width so no product bit is lost
`define MULT_PROD_WIDTH 64

`endif

//--- design/mult_data_pkg.sv
/*
 * Word types carried through the multiplier datapath
 */
`include "mult_macros.svh"

package mult_data_pkg;

	// Operand, magnitude or result word
	// Signedness is up to the user of the word
	typedef logic [`MULT_WIDTH-1:0] word_t;

	// Full double-width product
	typedef logic [`MULT_PROD_WIDTH-1:0] dword_t;

endpackage

//--- design/mult_array_pkg.sv
/*
 * Types describing one row of the shift-and-add array
 */
`include "mult_macros.svh"

package mult_array_pkg;

	// Running sum out of a row
	// Low bits are the sum, top bit is the row carry out
	typedef logic [`MULT_WIDTH:0] row_t;

	// Row number, also the multiplier bit the row picks
	typedef logic [$clog2(`MULT_WIDTH)-1:0] row_idx_t;

endpackage

//--- design/operand_conditioner.sv
/*
 * Operand capture stage that registers operand magnitudes and the
 * sign-flip flag on each multiply strobe
 */
`include "mult_macros.svh"

module operand_conditioner (
	input  logic                 clock,
	input  logic                 rst_n,
	input  mult_data_pkg::word_t data_operandA,
	input  mult_data_pkg::word_t data_operandB,
	input  logic                 ctrl_MULT,
	output mult_data_pkg::word_t mag_a,
	output mult_data_pkg::word_t mag_b,
	output logic                 neg,
	output logic                 stage_valid
);

	// Largest magnitude comes from the most negative operand
	localparam mult_data_pkg::word_t MAG_MAX =
		mult_data_pkg::word_t'(1) << (`MULT_WIDTH - 1);

	logic sign_a;
	logic sign_b;
	mult_data_pkg::word_t abs_a;
	mult_data_pkg::word_t abs_b;

	assign sign_a = data_operandA[`MULT_WIDTH-1];
	assign sign_b = data_operandB[`MULT_WIDTH-1];

	// Two's complement magnitude
	// -2^31 maps to 2^31 and still fits unsigned
	assign abs_a = sign_a ? (~data_operandA + 1'b1) : data_operandA;
	assign abs_b = sign_b ? (~data_operandB + 1'b1) : data_operandB;

	// Payload registers load only on a strobe
	always_ff @(posedge clock) begin
		if (ctrl_MULT) begin
			mag_a <= abs_a;
			mag_b <= abs_b;
			neg   <= sign_a ^ sign_b;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= ctrl_MULT;
		end
	end

	// A captured magnitude never exceeds 2^31
	a_mag_in_range: assert property (
		@(posedge clock) disable iff (!rst_n)
		stage_valid |-> (mag_a <= MAG_MAX) && (mag_b <= MAG_MAX)
	);

endmodule

//--- design/csa_row.sv
/*
 * One row of the array: partial-product AND gates feeding a
 * ripple of full-adder logic
 */
`include "mult_macros.svh"

module csa_row (
	input  mult_array_pkg::row_idx_t row,
	input  mult_data_pkg::word_t     mag_a,
	input  mult_data_pkg::word_t     mag_b,
	input  mult_array_pkg::row_t     sum_in,
	output mult_array_pkg::row_t     sum_out,
	output logic                     prod_bit
);

	mult_data_pkg::word_t pp;
	mult_data_pkg::word_t addend;
	mult_data_pkg::word_t row_sum;
	logic [`MULT_WIDTH:0] carry;

	// Partial product for this multiplier bit
	assign pp = mag_a & {`MULT_WIDTH{mag_b[row]}};

	// Previous row shifted down by one
	// Its bit 0 already left the array as a product bit
	assign addend = sum_in[`MULT_WIDTH:1];

	// No carry in, so bit 0 acts as a half adder
	assign carry[0] = 1'b0;

	genvar i;
	generate
		for (i = 0; i < `MULT_WIDTH; i++) begin : g_fa
			// XOR sum and majority carry
			assign row_sum[i] = pp[i] ^ addend[i] ^ carry[i];
			assign carry[i+1] = (pp[i] & addend[i]) |
				(pp[i] & carry[i]) |
				(addend[i] & carry[i]);
		end
	endgenerate

	// Carry out becomes the top bit of the running sum
	assign sum_out = {carry[`MULT_WIDTH], row_sum};

	// Lowest bit is final for this row
	assign prod_bit = row_sum[0];

endmodule

//--- design/array_multiplier.sv
/*
 * Unsigned shift-and-add array multiplier built from one
 * csa_row per multiplier bit
 */
`include "mult_macros.svh"

module array_multiplier (
	input  mult_data_pkg::word_t  mag_a,
	input  mult_data_pkg::word_t  mag_b,
	output mult_data_pkg::dword_t mag_prod
);

	// Running sums between rows
	// Entry 0 feeds row 0, entry N leaves the last row
	mult_array_pkg::row_t row_sum [0:`MULT_WIDTH];

	// One finished product bit per row
	mult_data_pkg::word_t low_bits;

	assign row_sum[0] = '0;

	genvar i;
	generate
		for (i = 0; i < `MULT_WIDTH; i++) begin : g_row
			csa_row u_row (
				.row      (mult_array_pkg::row_idx_t'(i)),
				.mag_a    (mag_a),
				.mag_b    (mag_b),
				.sum_in   (row_sum[i]),
				.sum_out  (row_sum[i+1]),
				.prod_bit (low_bits[i])
			);
		end
	endgenerate

	// Upper half comes straight from the last row, minus its
	// bit 0 which is already product bit 31
	assign mag_prod = {row_sum[`MULT_WIDTH][`MULT_WIDTH:1], low_bits};

endmodule

//--- design/product_finisher.sv
/*
 * Output stage with sign restore, overflow exception and the
 * registered result with its ready pulse
 */
`include "mult_macros.svh"

module product_finisher (
	input  logic                  clock,
	input  logic                  rst_n,
	input  mult_data_pkg::dword_t mag_prod,
	input  logic                  neg,
	input  logic                  stage_valid,
	output mult_data_pkg::word_t  data_result,
	output logic                  data_exception,
	output logic                  data_resultRDY
);

	// Largest magnitude a negative 32-bit result can carry is 2^31
	localparam mult_data_pkg::dword_t NEG_LIMIT =
		mult_data_pkg::dword_t'(1) << (`MULT_WIDTH - 1);
	// Largest positive 32-bit result is 2^31 - 1
	localparam mult_data_pkg::dword_t POS_LIMIT = NEG_LIMIT - 1'b1;

	mult_data_pkg::dword_t signed_prod;
	logic                  out_of_range;

	assign signed_prod = neg ? (~mag_prod + 1'b1) : mag_prod;

	// Product does not fit in 32 signed bits
	assign out_of_range = mag_prod > (neg ? NEG_LIMIT : POS_LIMIT);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			data_result    <= '0;
			data_exception <= 1'b0;
			data_resultRDY <= 1'b0;
		end else begin
			data_resultRDY <= stage_valid;
			// Outputs hold between results
			if (stage_valid) begin
				data_result    <= signed_prod[`MULT_WIDTH-1:0];
				data_exception <= out_of_range;
			end
		end
	end

	// An in-range nonzero result carries the sign of the product
	a_result_sign: assert property (
		@(posedge clock) disable iff (!rst_n)
		data_resultRDY && !data_exception && (data_result != '0)
			|-> data_result[`MULT_WIDTH-1] == $past(neg)
	);

endmodule

//--- design/multdiv.sv
/*
 * Top level of the pipelined signed 32x32 multiplier
 */
module multdiv (
	input  logic                 clock,
	input  logic                 rst_n,
	input  mult_data_pkg::word_t data_operandA,
	input  mult_data_pkg::word_t data_operandB,
	input  logic                 ctrl_MULT,
	output mult_data_pkg::word_t data_result,
	output logic                 data_exception,
	output logic                 data_resultRDY
);

	mult_data_pkg::word_t  mag_a;
	mult_data_pkg::word_t  mag_b;
	mult_data_pkg::dword_t mag_prod;
	logic                  neg;
	logic                  stage_valid;

	// Stage 1, operand magnitudes and sign
	operand_conditioner u_cond (
		.clock         (clock),
		.rst_n         (rst_n),
		.data_operandA (data_operandA),
		.data_operandB (data_operandB),
		.ctrl_MULT     (ctrl_MULT),
		.mag_a         (mag_a),
		.mag_b         (mag_b),
		.neg           (neg),
		.stage_valid   (stage_valid)
	);

	// Combinational array between the two register stages
	array_multiplier u_array (
		.mag_a    (mag_a),
		.mag_b    (mag_b),
		.mag_prod (mag_prod)
	);

	// Stage 2, sign restore and outputs
	product_finisher u_finish (
		.clock          (clock),
		.rst_n          (rst_n),
		.mag_prod       (mag_prod),
		.neg            (neg),
		.stage_valid    (stage_valid),
		.data_result    (data_result),
		.data_exception (data_exception),
		.data_resultRDY (data_resultRDY)
	);

endmodule

//--- test/tb_clock.sv
/*
 * Free-running testbench clock, 100 ns period
 */
module tb_clock (
	output logic clock
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam time HALF_PERIOD = 50ns;

	initial begin
		clock = 1'b0;
		forever begin
			#(HALF_PERIOD) clock = ~clock;
		end
	end

endmodule

//--- test/tb_multdiv.sv
/*
 * Testbench for the pipelined signed multiplier with random and corner
 * operands, back-to-back strobes, a product model and timeouts
 */
module tb_multdiv;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 20;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_SMALL = 100;
	localparam int NUM_STREAM = 50;

	logic        clock;
	logic        rst_n;
	logic [31:0] data_operandA;
	logic [31:0] data_operandB;
	logic        ctrl_MULT;
	logic [31:0] data_result;
	logic        data_exception;
	logic        data_resultRDY;

	// Expected {exception, result} per strobe in start order
	logic [32:0] expect_q[$];
	logic [31:0] last_result;
	logic        last_exception;
	int          exc_seen;
	int          no_exc_seen;

	tb_clock u_clk (
		.clock (clock)
	);

	multdiv uut (
		.clock          (clock),
		.rst_n          (rst_n),
		.data_operandA  (data_operandA),
		.data_operandB  (data_operandB),
		.ctrl_MULT      (ctrl_MULT),
		.data_result    (data_result),
		.data_exception (data_exception),
		.data_resultRDY (data_resultRDY)
	);

	task automatic stop_on_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERR %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			stop_on_failure();
		end
	endtask

	// Full signed product and the 32-bit signed range rule
	function automatic logic [32:0] model_product(input logic [31:0] a, input logic [31:0] b);
		longint sa;
		longint sb;
		longint p;
		logic   ovf;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		p = sa * sb;
		ovf = (p > 64'sd2147483647) || (p < -64'sd2147483648);
		return {ovf, p[31:0]};
	endfunction

	task automatic start_multiply(input logic [31:0] a, input logic [31:0] b);
		@(posedge clock);
		data_operandA <= a;
		data_operandB <= b;
		ctrl_MULT     <= 1'b1;
		expect_q.push_back(model_product(a, b));
	endtask

	task automatic check_result();
		logic [32:0] e;
		if (expect_q.size() == 0) begin
			$display("A result pulse arrived with no multiply outstanding");
			stop_on_failure();
		end
		e = expect_q.pop_front();
		check_value(data_result, e[31:0], "data_result");
		check_value(data_exception, e[32], "data_exception");
		if (e[32])
			exc_seen++;
		else
			no_exc_seen++;
		last_result = data_result;
		last_exception = data_exception;
	endtask

	// Outputs must hold and no pulse may appear while idle
	task automatic idle_hold(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			check_value(data_resultRDY, 1'b0, "data_resultRDY while idle");
			check_value(data_result, last_result, "data_result while idle");
			check_value(data_exception, last_exception, "data_exception while idle");
		end
	endtask

	task automatic single_multiply(input logic [31:0] a, input logic [31:0] b);
		int edges;
		bit got;
		start_multiply(a, b);
		// This edge is the start edge
		@(posedge clock);
		ctrl_MULT <= 1'b0;
		edges = 0;
		got = 0;
		while (!got && edges < TIMEOUT_CYCLES) begin
			@(negedge clock);
			if (data_resultRDY) begin
				got = 1;
			end else begin
				@(posedge clock);
				edges++;
			end
		end
		if (!got) begin
			$display("No result arrived within %0d cycles of a multiply strobe", TIMEOUT_CYCLES);
			stop_on_failure();
		end
		check_value(edges, 1, "edges from start edge to ready pulse");
		check_result();
		idle_hold(1);
	endtask

	task automatic stream_multiply(input int count);
		int cycle;
		int got;
		bit started;
		logic [31:0] a;
		logic [31:0] b;
		cycle = 0;
		got = 0;
		started = 0;
		while (got < count) begin
			@(posedge clock);
			if (cycle < count) begin
				a = $urandom;
				b = $urandom;
				data_operandA <= a;
				data_operandB <= b;
				ctrl_MULT     <= 1'b1;
				expect_q.push_back(model_product(a, b));
			end else begin
				ctrl_MULT <= 1'b0;
			end
			@(negedge clock);
			if (data_resultRDY) begin
				if (!started)
					check_value(cycle, 2, "cycles from first strobe to first pulse");
				started = 1;
				check_result();
				got++;
			end else if (started) begin
				$display("Result pulses stopped after %0d of %0d back-to-back strobes",
					got, count);
				stop_on_failure();
			end
			cycle++;
			if (cycle > count + TIMEOUT_CYCLES) begin
				$display("No result arrived for the back-to-back strobes in time");
				stop_on_failure();
			end
		end
		check_value(expect_q.size(), 0, "outstanding results after stream");
	endtask

	initial begin
		logic [31:0] corner [5];
		logic [31:0] a;
		logic [31:0] b;
		int i;
		int j;

		rst_n = 1'b0;
		ctrl_MULT = 1'b0;
		data_operandA = '0;
		data_operandB = '0;
		last_result = '0;
		last_exception = 1'b0;
		exc_seen = 0;
		no_exc_seen = 0;
		corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
		void'($urandom(32'h34b43333));

		repeat (3) @(posedge clock);
		rst_n <= 1'b1;

		// Reset values and quiet cycles without strobes
		@(negedge clock);
		check_value(data_resultRDY, 1'b0, "data_resultRDY after reset");
		check_value(data_result, 32'h0, "data_result after reset");
		check_value(data_exception, 1'b0, "data_exception after reset");
		idle_hold(5);

		for (i = 0; i < NUM_RANDOM; i++) begin
			single_multiply($urandom, $urandom);
		end

		// Operands near +-2^17 so products straddle the 32-bit limit
		exc_seen = 0;
		no_exc_seen = 0;
		for (i = 0; i < NUM_SMALL; i++) begin
			a = 32'($urandom_range(32'h40000)) - 32'h20000;
			b = 32'($urandom_range(32'h40000)) - 32'h20000;
			single_multiply(a, b);
		end
		if (exc_seen == 0 || no_exc_seen == 0) begin
			$display("Small-range operands did not produce both exception outcomes");
			stop_on_failure();
		end

		for (i = 0; i < 5; i++) begin
			for (j = 0; j < 5; j++) begin
				single_multiply(corner[i], corner[j]);
			end
		end

		stream_multiply(NUM_STREAM);
		idle_hold(8);

		$display("All tests passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+design
design/mult_data_pkg.sv
design/mult_array_pkg.sv
design/operand_conditioner.sv
design/csa_row.sv
design/array_multiplier.sv
design/product_finisher.sv
design/multdiv.sv
test/tb_clock.sv
test/tb_multdiv.sv

//--- run.sh
#!/bin/sh
# Build the multiplier testbench with Verilator and run it.
# Success means the pass message shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_multdiv \
	-f filelist.f -o tb_multdiv_sim \
	&& ./obj_dir/tb_multdiv_sim | grep -F "All tests passed" \
	|| exit 1

exit 0
